// File: logic/dram_timing_pkg.sv
//--------------------
// geometry, timing values and shared types
// of the four-slot DRAM timing tracker
// sub-slot lag and countdown decay helpers
//--------------------

package dram_timing_pkg;

    //--------------------
    // geometry
    //--------------------

    // commands issued per clock
    localparam int NUM_SLOTS = 4;
    localparam int NUM_RNK = 2;
    localparam int NUM_BG = 2;
    localparam int NUM_BNK = 4;
    // flat bank index is {rank, bg, bnk} from msb to lsb
    localparam int NUM_BNK_TOT = NUM_RNK * NUM_BG * NUM_BNK;
    localparam int BNK_IDX_W = $clog2(NUM_BNK_TOT);
    localparam int SLOT_W = $clog2(NUM_SLOTS);
    // bits per countdown
    localparam int TIME_WIDTH = 6;
    // activates remembered per rank for tFAW
    localparam int FAW_DEPTH = 4;

    typedef logic [TIME_WIDTH-1:0] time_t;
    typedef logic [SLOT_W-1:0] slot_idx_t;
    typedef logic [BNK_IDX_W-1:0] bank_idx_t;
    typedef logic [$clog2(FAW_DEPTH)-1:0] faw_ptr_t;

    //--------------------
    // timing, in sub-slots
    //--------------------

    localparam time_t T_RCD = time_t'(14);
    localparam time_t T_RP = time_t'(14);
    localparam time_t T_RAS = time_t'(32);
    // largest value any table can hold
    localparam time_t T_RC = time_t'(46);
    localparam time_t T_RRD_L = time_t'(6);
    localparam time_t T_RRD_S = time_t'(4);
    localparam time_t T_RTP = time_t'(6);
    localparam time_t T_CCD_L = time_t'(6);
    localparam time_t T_CCD_S = time_t'(4);
    localparam time_t T_RTW = time_t'(8);
    localparam time_t T_WTR_L = time_t'(12);
    localparam time_t T_WTR_S = time_t'(4);
    // write recovery before precharge
    localparam time_t T_WTP = time_t'(18);
    localparam time_t T_FAW = time_t'(20);

    //--------------------
    // command and table types
    //--------------------

    typedef enum logic [2:0] {
        NOP = 3'd0,
        ACT = 3'd1,
        PRE = 3'd2,
        RD  = 3'd3,
        WR  = 3'd4
    } cmd_op_e;

    // one scheduler command, nop marks an empty slot
    typedef struct packed {
        cmd_op_e    op;
        logic       rank;
        logic       bg;
        logic [1:0] bnk;
    } slot_cmd_t;

    // index 0 is the earliest sub-slot
    typedef slot_cmd_t [NUM_SLOTS-1:0] slot_bus_t;

    // wait before each command type may go to a bank
    typedef struct packed {
        time_t pre;
        time_t act;
        time_t rd;
        time_t wr;
    } bank_timing_t;

    typedef bank_timing_t [NUM_BNK_TOT-1:0] bank_table_t;
    typedef bank_timing_t [NUM_SLOTS-1:0][NUM_BNK_TOT-1:0] slot_const_t;
    typedef time_t [NUM_RNK-1:0] rank_time_t;

    // remove the sub-slots left in the cycle after the issuing slot, floor at 0
    function automatic time_t slot_adjust(time_t base, int unsigned slot);
        time_t lag;
        lag = time_t'(NUM_SLOTS - 1 - slot);
        return (base > lag) ? time_t'(base - lag) : '0;
    endfunction

    // one clock worth of decay
    function automatic time_t sat_dec(time_t t);
        return (t > time_t'(NUM_SLOTS)) ? time_t'(t - time_t'(NUM_SLOTS)) : '0;
    endfunction

    function automatic bank_timing_t timing_dec(bank_timing_t t);
        bank_timing_t d;
        d.pre = sat_dec(t.pre);
        d.act = sat_dec(t.act);
        d.rd  = sat_dec(t.rd);
        d.wr  = sat_dec(t.wr);
        return d;
    endfunction

endpackage

// File: logic/constraint_calc.sv
//--------------------
// constraint lookup for every slot and bank
// relation decode, rule table, sub-slot lag
//--------------------

module constraint_calc (
    input  dram_timing_pkg::slot_bus_t   i_slots,
    output dram_timing_pkg::slot_const_t o_slot_const
);

    for (genvar s = 0; s < dram_timing_pkg::NUM_SLOTS; s++) begin : g_slot
        for (genvar b = 0; b < dram_timing_pkg::NUM_BNK_TOT; b++) begin : g_bank
            // flat index of the bank this lane serves
            localparam dram_timing_pkg::bank_idx_t BANK_IDX =
                dram_timing_pkg::bank_idx_t'(b);

            logic same_bank;
            logic same_grp;
            logic same_rank;
            // constraint before the lag is taken off
            dram_timing_pkg::bank_timing_t base;

            //--------------------
            // relation decode
            //--------------------

            // index layout {rank, bg, bnk[1:0]}
            assign same_bank = ({i_slots[s].rank, i_slots[s].bg, i_slots[s].bnk} == BANK_IDX);
            assign same_grp  = ({i_slots[s].rank, i_slots[s].bg} == BANK_IDX[3:2]);
            assign same_rank = (i_slots[s].rank == BANK_IDX[3]);

            //--------------------
            // rule table
            //--------------------

            // same bank checked first since it also matches group and rank
            always_comb begin
                base = '0;
                case (i_slots[s].op)
                    dram_timing_pkg::ACT: begin
                        if (same_bank) begin
                            // tRAS rides on the pre entry
                            base.pre = dram_timing_pkg::T_RAS;
                            base.act = dram_timing_pkg::T_RC;
                            base.rd  = dram_timing_pkg::T_RCD;
                            base.wr  = dram_timing_pkg::T_RCD;
                        end else if (same_grp) begin
                            base.act = dram_timing_pkg::T_RRD_L;
                        end else if (same_rank) begin
                            base.act = dram_timing_pkg::T_RRD_S;
                        end
                    end
                    dram_timing_pkg::PRE: begin
                        // precharge only holds off its own bank
                        if (same_bank) begin
                            base.act = dram_timing_pkg::T_RP;
                        end
                    end
                    dram_timing_pkg::RD: begin
                        if (same_bank) begin
                            base.pre = dram_timing_pkg::T_RTP;
                            base.rd  = dram_timing_pkg::T_CCD_L;
                            base.wr  = dram_timing_pkg::T_RTW;
                        end else if (same_grp) begin
                            base.rd = dram_timing_pkg::T_CCD_L;
                            base.wr = dram_timing_pkg::T_RTW;
                        end else if (same_rank) begin
                            base.rd = dram_timing_pkg::T_CCD_S;
                            base.wr = dram_timing_pkg::T_RTW;
                        end
                    end
                    dram_timing_pkg::WR: begin
                        if (same_bank) begin
                            base.pre = dram_timing_pkg::T_WTP;
                            base.rd  = dram_timing_pkg::T_WTR_L;
                            base.wr  = dram_timing_pkg::T_CCD_L;
                        end else if (same_grp) begin
                            base.rd = dram_timing_pkg::T_WTR_L;
                            base.wr = dram_timing_pkg::T_CCD_L;
                        end else if (same_rank) begin
                            base.rd = dram_timing_pkg::T_WTR_S;
                            base.wr = dram_timing_pkg::T_CCD_S;
                        end
                    end
                    // nop and other rank leave all zero
                    default: base = '0;
                endcase
            end

            // later slots have fewer sub-slots left in this cycle
            assign o_slot_const[s][b].pre = dram_timing_pkg::slot_adjust(base.pre, s);
            assign o_slot_const[s][b].act = dram_timing_pkg::slot_adjust(base.act, s);
            assign o_slot_const[s][b].rd  = dram_timing_pkg::slot_adjust(base.rd, s);
            assign o_slot_const[s][b].wr  = dram_timing_pkg::slot_adjust(base.wr, s);
        end
    end

endmodule

// File: logic/bank_timetable.sv
//--------------------
// intra-bank and inter-bank countdown tables
// load on a hit, decay by one clock otherwise
// checks on act and cas count per cycle
//--------------------

module bank_timetable (
    input  logic                         i_clk,
    input  logic                         i_rstn,
    input  dram_timing_pkg::slot_bus_t   i_slots,
    input  dram_timing_pkg::slot_const_t i_slot_const,
    output dram_timing_pkg::bank_table_t o_intra,
    output dram_timing_pkg::bank_table_t o_inter
);

    // per-slot command class
    logic [dram_timing_pkg::NUM_SLOTS-1:0] is_act;
    logic [dram_timing_pkg::NUM_SLOTS-1:0] is_cas;
    logic                                  act_vld;
    logic                                  cas_vld;
    dram_timing_pkg::slot_idx_t            act_idx;
    dram_timing_pkg::slot_idx_t            cas_idx;

    // registered tables and their next values
    dram_timing_pkg::bank_table_t intra_q;
    dram_timing_pkg::bank_table_t inter_q;
    dram_timing_pkg::bank_table_t intra_nxt;
    dram_timing_pkg::bank_table_t inter_nxt;

    //--------------------
    // act and cas slot search
    //--------------------

    // walk down so the lowest slot is the one kept
    always_comb begin
        act_idx = '0;
        cas_idx = '0;
        for (int s = dram_timing_pkg::NUM_SLOTS - 1; s >= 0; s--) begin
            is_act[s] = (i_slots[s].op == dram_timing_pkg::ACT);
            is_cas[s] = (i_slots[s].op == dram_timing_pkg::RD) ||
                        (i_slots[s].op == dram_timing_pkg::WR);
            if (is_act[s]) begin
                act_idx = dram_timing_pkg::slot_idx_t'(s);
            end
            if (is_cas[s]) begin
                cas_idx = dram_timing_pkg::slot_idx_t'(s);
            end
        end
        act_vld = |is_act;
        cas_vld = |is_cas;
    end

    //--------------------
    // per-bank update
    //--------------------

    for (genvar b = 0; b < dram_timing_pkg::NUM_BNK_TOT; b++) begin : g_bank
        localparam dram_timing_pkg::bank_idx_t BANK_IDX =
            dram_timing_pkg::bank_idx_t'(b);

        logic                       hit;
        dram_timing_pkg::slot_idx_t hit_idx;

        // first non-nop slot aimed at this bank
        always_comb begin
            hit = 1'b0;
            hit_idx = '0;
            for (int s = dram_timing_pkg::NUM_SLOTS - 1; s >= 0; s--) begin
                if ((i_slots[s].op != dram_timing_pkg::NOP) &&
                    ({i_slots[s].rank, i_slots[s].bg, i_slots[s].bnk} == BANK_IDX)) begin
                    hit = 1'b1;
                    hit_idx = dram_timing_pkg::slot_idx_t'(s);
                end
            end
        end

        // own command reloads all four fields
        assign intra_nxt[b] = hit ? i_slot_const[hit_idx][b]
                                  : dram_timing_pkg::timing_dec(intra_q[b]);

        // other banks never hold off a precharge
        assign inter_nxt[b].pre = '0;
        assign inter_nxt[b].act = act_vld ? i_slot_const[act_idx][b].act
                                          : dram_timing_pkg::sat_dec(inter_q[b].act);
        // rd and wr follow the single cas of the cycle
        assign inter_nxt[b].rd  = cas_vld ? i_slot_const[cas_idx][b].rd
                                          : dram_timing_pkg::sat_dec(inter_q[b].rd);
        assign inter_nxt[b].wr  = cas_vld ? i_slot_const[cas_idx][b].wr
                                          : dram_timing_pkg::sat_dec(inter_q[b].wr);

        // tRC is the longest rule so no entry may sit above it
        a_intra_bound: assert property (@(posedge i_clk) disable iff (!i_rstn)
            (intra_q[b].pre <= dram_timing_pkg::T_RC) &&
            (intra_q[b].act <= dram_timing_pkg::T_RC) &&
            (intra_q[b].rd  <= dram_timing_pkg::T_RC) &&
            (intra_q[b].wr  <= dram_timing_pkg::T_RC))
            else $error("intra entry of bank %0d above tRC", b);
    end

    //--------------------
    // table registers
    //--------------------

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            intra_q <= '0;
            inter_q <= '0;
        end else begin
            intra_q <= intra_nxt;
            inter_q <= inter_nxt;
        end
    end

    assign o_intra = intra_q;
    assign o_inter = inter_q;

    // the scheduler may issue one act and one cas per clock
    a_one_act: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $countones(is_act) <= 1)
        else $error("more than one ACT in a cycle");

    a_one_cas: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $countones(is_cas) <= 1)
        else $error("more than one CAS in a cycle");

endmodule

// File: logic/faw_window.sv
//--------------------
// four-activate window of one rank
// rotating pointer marks the oldest act
//--------------------

module faw_window #(
    parameter int unsigned RANK_ID = 0
) (
    input  logic                       i_clk,
    input  logic                       i_rstn,
    input  dram_timing_pkg::slot_bus_t i_slots,
    output dram_timing_pkg::time_t     o_faw_last
);

    // rank bit this window compares against
    localparam logic RANK_BIT = 1'(RANK_ID);

    logic                                                  act_hit;
    dram_timing_pkg::slot_idx_t                            act_slot;
    dram_timing_pkg::time_t [dram_timing_pkg::FAW_DEPTH-1:0] win_q;
    dram_timing_pkg::time_t [dram_timing_pkg::FAW_DEPTH-1:0] win_nxt;
    dram_timing_pkg::faw_ptr_t                             ptr_q;

    // act to this rank, at most one per cycle
    always_comb begin
        act_hit = 1'b0;
        act_slot = '0;
        for (int s = dram_timing_pkg::NUM_SLOTS - 1; s >= 0; s--) begin
            if ((i_slots[s].op == dram_timing_pkg::ACT) && (i_slots[s].rank == RANK_BIT)) begin
                act_hit = 1'b1;
                act_slot = dram_timing_pkg::slot_idx_t'(s);
            end
        end
    end

    //--------------------
    // window update
    //--------------------

    // all entries age, the pointed one is overwritten on an act
    always_comb begin
        for (int i = 0; i < dram_timing_pkg::FAW_DEPTH; i++) begin
            win_nxt[i] = dram_timing_pkg::sat_dec(win_q[i]);
        end
        if (act_hit) begin
            win_nxt[ptr_q] = dram_timing_pkg::slot_adjust(dram_timing_pkg::T_FAW, act_slot);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            win_q <= '0;
            ptr_q <= '0;
        end else begin
            win_q <= win_nxt;
            if (act_hit) begin
                ptr_q <= dram_timing_pkg::faw_ptr_t'(ptr_q + 1'b1);
            end
        end
    end

    // after the advance the pointer sits on the oldest act
    assign o_faw_last = win_q[ptr_q];

    // window only rotates on this rank's own act
    a_ptr_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !act_hit |=> $stable(ptr_q))
        else $error("tFAW pointer of rank %0d moved without an ACT", RANK_ID);

endmodule

// File: logic/timing_tracker_top.sv
//--------------------
// DRAM command timing tracker top level
// constraint lookup, bank tables, tFAW per rank
//--------------------

module timing_tracker_top (
    input  logic                         i_clk,
    input  logic                         i_rstn,
    // four scheduler commands per clock
    input  dram_timing_pkg::slot_bus_t   i_slots,
    // registered countdown tables
    output dram_timing_pkg::bank_table_t o_intra,
    output dram_timing_pkg::bank_table_t o_inter,
    // oldest act in each rank's window
    output dram_timing_pkg::rank_time_t  o_faw_last
);

    // constraints each slot would place on each bank
    dram_timing_pkg::slot_const_t slot_const;

    //--------------------
    // constraint lookup
    //--------------------

    constraint_calc u_calc (
        .i_slots      (i_slots),
        .o_slot_const (slot_const)
    );

    //--------------------
    // bank tables
    //--------------------

    bank_timetable u_table (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_slots      (i_slots),
        .i_slot_const (slot_const),
        .o_intra      (o_intra),
        .o_inter      (o_inter)
    );

    // one window per rank
    for (genvar r = 0; r < dram_timing_pkg::NUM_RNK; r++) begin : g_faw
        faw_window #(
            .RANK_ID (r)
        ) u_faw (
            .i_clk      (i_clk),
            .i_rstn     (i_rstn),
            .i_slots    (i_slots),
            .o_faw_last (o_faw_last[r])
        );
    end

endmodule

// File: testbench/tb_timing_tracker.sv
//--------------------
// testbench for the DRAM timing tracker
// clock, reset, directed and random slots
// reference model and checking assertions
//--------------------

module tb_timing_tracker;
    timeunit 1ns;
    timeprecision 1ps;

    // run limit covers about 300 cycles of stimulus plus margin
    localparam int MAX_CYCLES = 400;

    // where a command's target sits relative to a bank
    typedef enum int {REL_BANK, REL_GROUP, REL_RANK, REL_NONE} rel_e;

    logic                         i_clk = 1'b0;
    logic                         i_rstn;
    dram_timing_pkg::slot_bus_t   i_slots;
    dram_timing_pkg::bank_table_t o_intra;
    dram_timing_pkg::bank_table_t o_inter;
    dram_timing_pkg::rank_time_t  o_faw_last;

    // reference model state
    dram_timing_pkg::bank_table_t exp_intra;
    dram_timing_pkg::bank_table_t exp_inter;
    dram_timing_pkg::rank_time_t  exp_faw;
    dram_timing_pkg::time_t       faw_win [dram_timing_pkg::NUM_RNK][dram_timing_pkg::FAW_DEPTH];
    int                           faw_ptr [dram_timing_pkg::NUM_RNK];
    int                           cycle_cnt = 0;

    timing_tracker_top DUT (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_slots    (i_slots),
        .o_intra    (o_intra),
        .o_inter    (o_inter),
        .o_faw_last (o_faw_last)
    );

    always #20 i_clk = ~i_clk;

    //--------------------
    // model helpers
    //--------------------

    // bank index bits are rank, group, bank from msb down
    function automatic rel_e relation_of(dram_timing_pkg::slot_cmd_t c, int b);
        if (int'(c.rank) != b / 8) return REL_NONE;
        if (int'(c.bg) != (b / 4) % 2) return REL_RANK;
        if (int'(c.bnk) != b % 4) return REL_GROUP;
        return REL_BANK;
    endfunction

    function automatic dram_timing_pkg::bank_timing_t base_timing(
        dram_timing_pkg::cmd_op_e op, rel_e rel);
        dram_timing_pkg::bank_timing_t t;
        t = '0;
        case (op)
            dram_timing_pkg::ACT: begin
                if (rel == REL_BANK) begin
                    t.pre = dram_timing_pkg::T_RAS;
                    t.act = dram_timing_pkg::T_RC;
                    t.rd = dram_timing_pkg::T_RCD;
                    t.wr = dram_timing_pkg::T_RCD;
                end else if (rel == REL_GROUP) begin
                    t.act = dram_timing_pkg::T_RRD_L;
                end else if (rel == REL_RANK) begin
                    t.act = dram_timing_pkg::T_RRD_S;
                end
            end
            dram_timing_pkg::PRE: begin
                if (rel == REL_BANK) t.act = dram_timing_pkg::T_RP;
            end
            dram_timing_pkg::RD: begin
                if (rel == REL_BANK) t.pre = dram_timing_pkg::T_RTP;
                if (rel != REL_NONE) t.wr = dram_timing_pkg::T_RTW;
                if (rel == REL_BANK || rel == REL_GROUP) t.rd = dram_timing_pkg::T_CCD_L;
                if (rel == REL_RANK) t.rd = dram_timing_pkg::T_CCD_S;
            end
            dram_timing_pkg::WR: begin
                if (rel == REL_BANK) t.pre = dram_timing_pkg::T_WTP;
                if (rel == REL_BANK || rel == REL_GROUP) begin
                    t.rd = dram_timing_pkg::T_WTR_L;
                    t.wr = dram_timing_pkg::T_CCD_L;
                end else if (rel == REL_RANK) begin
                    t.rd = dram_timing_pkg::T_WTR_S;
                    t.wr = dram_timing_pkg::T_CCD_S;
                end
            end
            default: t = '0;
        endcase
        return t;
    endfunction

    // base minus the sub-slots still left after slot s and never below 0
    function automatic dram_timing_pkg::time_t after_lag(dram_timing_pkg::time_t base, int s);
        int v;
        v = int'(base) - (3 - s);
        if (v < 0) v = 0;
        return dram_timing_pkg::time_t'(v);
    endfunction

    function automatic dram_timing_pkg::time_t decay_one(dram_timing_pkg::time_t t);
        int v;
        v = int'(t) - 4;
        return (v > 0) ? dram_timing_pkg::time_t'(v) : '0;
    endfunction

    function automatic dram_timing_pkg::bank_timing_t decay_entry(
        dram_timing_pkg::bank_timing_t e);
        dram_timing_pkg::bank_timing_t d;
        d.pre = decay_one(e.pre);
        d.act = decay_one(e.act);
        d.rd = decay_one(e.rd);
        d.wr = decay_one(e.wr);
        return d;
    endfunction

    // what command c in slot s asks of bank b
    function automatic dram_timing_pkg::bank_timing_t imposed(
        dram_timing_pkg::slot_cmd_t c, int s, int b);
        dram_timing_pkg::bank_timing_t t;
        dram_timing_pkg::bank_timing_t res;
        t = base_timing(c.op, relation_of(c, b));
        res.pre = after_lag(t.pre, s);
        res.act = after_lag(t.act, s);
        res.rd = after_lag(t.rd, s);
        res.wr = after_lag(t.wr, s);
        return res;
    endfunction

    function automatic dram_timing_pkg::bank_table_t next_intra(
        dram_timing_pkg::bank_table_t cur, dram_timing_pkg::slot_bus_t slots);
        dram_timing_pkg::bank_table_t nxt;
        bit found;
        for (int b = 0; b < dram_timing_pkg::NUM_BNK_TOT; b++) begin
            found = 1'b0;
            nxt[b] = decay_entry(cur[b]);
            for (int s = 0; s < dram_timing_pkg::NUM_SLOTS; s++) begin
                if (!found && slots[s].op != dram_timing_pkg::NOP &&
                    relation_of(slots[s], b) == REL_BANK) begin
                    found = 1'b1;
                    nxt[b] = imposed(slots[s], s, b);
                end
            end
        end
        return nxt;
    endfunction

    function automatic dram_timing_pkg::bank_table_t next_inter(
        dram_timing_pkg::bank_table_t cur, dram_timing_pkg::slot_bus_t slots);
        dram_timing_pkg::bank_table_t nxt;
        dram_timing_pkg::bank_timing_t from_cmd;
        int act_s;
        int cas_s;
        act_s = -1;
        cas_s = -1;
        for (int s = 0; s < dram_timing_pkg::NUM_SLOTS; s++) begin
            if (act_s < 0 && slots[s].op == dram_timing_pkg::ACT) act_s = s;
            if (cas_s < 0 && (slots[s].op == dram_timing_pkg::RD ||
                              slots[s].op == dram_timing_pkg::WR)) cas_s = s;
        end
        for (int b = 0; b < dram_timing_pkg::NUM_BNK_TOT; b++) begin
            nxt[b] = decay_entry(cur[b]);
            nxt[b].pre = '0;
            if (act_s >= 0) begin
                from_cmd = imposed(slots[act_s], act_s, b);
                nxt[b].act = from_cmd.act;
            end
            if (cas_s >= 0) begin
                from_cmd = imposed(slots[cas_s], cas_s, b);
                nxt[b].rd = from_cmd.rd;
                nxt[b].wr = from_cmd.wr;
            end
        end
        return nxt;
    endfunction

    //--------------------
    // reference model
    //--------------------

    always @(posedge i_clk) begin : model_regs
        bit hit;
        int hit_slot;
        cycle_cnt <= cycle_cnt + 1;
        if (!i_rstn) begin
            exp_intra <= '0;
            exp_inter <= '0;
            for (int r = 0; r < dram_timing_pkg::NUM_RNK; r++) begin
                faw_ptr[r] <= 0;
                for (int i = 0; i < dram_timing_pkg::FAW_DEPTH; i++) faw_win[r][i] <= '0;
            end
        end else begin
            exp_intra <= next_intra(exp_intra, i_slots);
            exp_inter <= next_inter(exp_inter, i_slots);
            for (int r = 0; r < dram_timing_pkg::NUM_RNK; r++) begin
                hit = 1'b0;
                hit_slot = 0;
                for (int s = 0; s < dram_timing_pkg::NUM_SLOTS; s++) begin
                    if (!hit && i_slots[s].op == dram_timing_pkg::ACT &&
                        int'(i_slots[s].rank) == r) begin
                        hit = 1'b1;
                        hit_slot = s;
                    end
                end
                // the entry at the pointer takes the new act while the rest age
                for (int i = 0; i < dram_timing_pkg::FAW_DEPTH; i++) begin
                    faw_win[r][i] <= (hit && i == faw_ptr[r]) ?
                        after_lag(dram_timing_pkg::T_FAW, hit_slot) : decay_one(faw_win[r][i]);
                end
                if (hit) faw_ptr[r] <= (faw_ptr[r] + 1) % dram_timing_pkg::FAW_DEPTH;
            end
        end
    end

    // oldest act of each rank
    always_comb begin
        for (int r = 0; r < dram_timing_pkg::NUM_RNK; r++) exp_faw[r] = faw_win[r][faw_ptr[r]];
    end

    //--------------------
    // checks
    //--------------------

    a_intra: assert property (@(posedge i_clk) (cycle_cnt > 0) |-> (o_intra == exp_intra))
        else begin
            $display("ERR %0t o_intra expected %h actual %h",
                     $time, $sampled(exp_intra), $sampled(o_intra));
            $display("Test failures found");
            $fatal(1, "intra table mismatch");
        end

    a_inter: assert property (@(posedge i_clk) (cycle_cnt > 0) |-> (o_inter == exp_inter))
        else begin
            $display("ERR %0t o_inter expected %h actual %h",
                     $time, $sampled(exp_inter), $sampled(o_inter));
            $display("Test failures found");
            $fatal(1, "inter table mismatch");
        end

    a_faw: assert property (@(posedge i_clk) (cycle_cnt > 0) |-> (o_faw_last == exp_faw))
        else begin
            $display("ERR %0t o_faw_last expected %h actual %h",
                     $time, $sampled(exp_faw), $sampled(o_faw_last));
            $display("Test failures found");
            $fatal(1, "tFAW value mismatch");
        end

    // a reset edge clears everything whatever the slots hold
    a_reset_clear: assert property (@(posedge i_clk)
        !i_rstn |=> (o_intra == '0) && (o_inter == '0) && (o_faw_last == '0))
        else begin
            $display("ERR %0t o_intra/o_inter/o_faw_last expected 0 actual %h %h %h",
                     $time, $sampled(o_intra), $sampled(o_inter), $sampled(o_faw_last));
            $display("Test failures found");
            $fatal(1, "outputs not cleared by reset");
        end

    always @(posedge i_clk) begin
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    //--------------------
    // stimulus
    //--------------------

    function automatic dram_timing_pkg::slot_cmd_t make_cmd(
        dram_timing_pkg::cmd_op_e op, int rank, int bg, int bnk);
        dram_timing_pkg::slot_cmd_t c;
        c.op = op;
        c.rank = 1'(rank);
        c.bg = 1'(bg);
        c.bnk = 2'(bnk);
        return c;
    endfunction

    function automatic dram_timing_pkg::slot_cmd_t random_cmd(dram_timing_pkg::cmd_op_e op);
        return make_cmd(op, int'($urandom % 2), int'($urandom % 2), int'($urandom % 4));
    endfunction

    // any number of precharges with at most one act and one cas
    function automatic dram_timing_pkg::slot_bus_t random_bus();
        dram_timing_pkg::slot_bus_t bus;
        int act_s;
        int cas_s;
        bus = '0;
        act_s = -1;
        for (int s = 0; s < dram_timing_pkg::NUM_SLOTS; s++) begin
            if ($urandom % 3 == 0) bus[s] = random_cmd(dram_timing_pkg::PRE);
        end
        if ($urandom % 4 != 0) begin
            act_s = int'($urandom % 4);
            bus[act_s] = random_cmd(dram_timing_pkg::ACT);
        end
        cas_s = int'($urandom % 4);
        if (cas_s != act_s && $urandom % 4 != 0) begin
            bus[cas_s] = random_cmd(($urandom % 2 == 0) ? dram_timing_pkg::RD
                                                        : dram_timing_pkg::WR);
        end
        return bus;
    endfunction

    task automatic drive_slots(input dram_timing_pkg::slot_bus_t bus);
        @(posedge i_clk);
        i_slots <= bus;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_slots('0);
    endtask

    initial begin
        dram_timing_pkg::slot_bus_t bus;
        i_rstn = 1'b0;
        i_slots = '0;
        void'($urandom(13896));

        // reset for 4 cycles with an act landing while it is held
        for (int i = 0; i < 4; i++) begin
            bus = '0;
            if (i == 1) bus[0] = make_cmd(dram_timing_pkg::ACT, 0, 0, 0);
            @(posedge i_clk);
            i_slots <= bus;
            if (i == 3) i_rstn <= 1'b1;
        end

        // act in slot 1, then decay to zero
        bus = '0;
        bus[1] = make_cmd(dram_timing_pkg::ACT, 0, 1, 2);
        drive_slots(bus);
        idle_cycles(13);

        // act in the last slot of rank 1
        bus = '0;
        bus[3] = make_cmd(dram_timing_pkg::ACT, 1, 0, 1);
        drive_slots(bus);
        idle_cycles(3);

        // rd before pre to one bank, then pre before wr to another
        bus = '0;
        bus[0] = make_cmd(dram_timing_pkg::RD, 0, 0, 3);
        bus[2] = make_cmd(dram_timing_pkg::PRE, 0, 0, 3);
        drive_slots(bus);
        bus = '0;
        bus[1] = make_cmd(dram_timing_pkg::PRE, 1, 1, 0);
        bus[3] = make_cmd(dram_timing_pkg::WR, 1, 1, 0);
        drive_slots(bus);
        idle_cycles(6);

        // five back-to-back acts fill and wrap the rank 0 window
        for (int i = 0; i < 5; i++) begin
            bus = '0;
            bus[i % 4] = make_cmd(dram_timing_pkg::ACT, 0, i % 2, i % 4);
            drive_slots(bus);
        end
        idle_cycles(8);

        for (int i = 0; i < 250; i++) drive_slots(random_bus());
        idle_cycles(2);
        @(negedge i_clk);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: filelist.f
logic/dram_timing_pkg.sv
logic/constraint_calc.sv
logic/bank_timetable.sv
logic/faw_window.sv
logic/timing_tracker_top.sv
testbench/tb_timing_tracker.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the timing tracker testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_timing_tracker \
    -f filelist.f -o sim_tb &&
{
    sim_out="$(./obj_dir/sim_tb 2>&1)"
    printf '%s\n' "$sim_out"
    printf '%s\n' "$sim_out" | grep -qxF "All tests passed!"
} &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
